/* filelist.f */
+incdir+hw
hw/dedup_mem_pkg.sv
hw/dedup_track_pkg.sv
hw/dedup_read_tracker.sv
hw/dedup_request_path.sv
hw/dedup_chain_store.sv
hw/dedup_rsp_fifo.sv
hw/dedup_chain_walker.sv
hw/dedup_reads_top.sv
tb/tb_dedup_reads.sv

/* hw/dedup_chain_store.sv */
// Chain store
// Chain length per base read and the next-pointer link per read, both
// indexed by heap index. The length RAM has a registered read with a
// write-through path, the link array is read combinationally

`timescale 1ns/10ps
`include "dedup_config.svh"

module dedup_chain_store
(
    input  logic clk,
    input  logic len_wr_en,
    input  dedup_mem_pkg::heap_idx_t len_wr_idx,
    input  dedup_track_pkg::chain_len_t len_wr_data,
    input  dedup_mem_pkg::heap_idx_t len_rd_idx,
    output dedup_track_pkg::chain_len_t len_rd_data,
    input  logic link_wr_en,
    input  dedup_mem_pkg::heap_idx_t link_wr_idx,
    input  dedup_mem_pkg::heap_idx_t link_wr_next,
    input  dedup_mem_pkg::heap_idx_t link_rd_idx,
    output dedup_mem_pkg::heap_idx_t link_rd_next
);
    import dedup_mem_pkg::*;
    import dedup_track_pkg::*;

    localparam int N_READS = 1 << `DEDUP_HEAP_IDX_BITS;

    chain_len_t len_ram [N_READS];
    heap_idx_t next_ram [N_READS];

    always_ff @(posedge clk)
    begin
        if (len_wr_en)
        begin
            len_ram[len_wr_idx] <= len_wr_data;
        end

        // A link added in the same cycle as the read must still count
        len_rd_data <= (len_wr_en && len_wr_idx == len_rd_idx) ? len_wr_data
                                                               : len_ram[len_rd_idx];
    end

    always_ff @(posedge clk)
    begin
        if (link_wr_en)
        begin
            next_ram[link_wr_idx] <= link_wr_next;
        end
    end

    assign link_rd_next = next_ram[link_rd_idx];

endmodule

/* hw/dedup_chain_walker.sv */
// Chain walker
// Emits each base response from the FIFO, then one response per chained
// read on the following cycles by following the next pointers. Also counts
// chained responses still owed and raises almost_full before the response
// FIFO can run out of room

`timescale 1ns/10ps
`include "dedup_config.svh"

module dedup_chain_walker
(
    input  logic clk,
    input  logic reset,
    input  dedup_mem_pkg::rd_rsp_t first_rsp,
    input  dedup_track_pkg::chain_len_t first_len,
    input  logic not_empty,
    output logic deq,
    output dedup_mem_pkg::heap_idx_t link_rd_idx,
    input  dedup_mem_pkg::heap_idx_t link_rd_next,
    input  logic link_match,
    output dedup_mem_pkg::rd_rsp_t rsp_out,
    output logic almost_full
);
    import dedup_track_pkg::*;

    localparam int CNT_BITS = $clog2(`DEDUP_RSP_FIFO_DEPTH) + 1;
    localparam logic [CNT_BITS-1:0] AF_LEVEL =
        `DEDUP_RSP_FIFO_DEPTH - `DEDUP_ALMOST_FULL_MARGIN;

    chain_len_t links_rem;
    logic walking;
    logic [CNT_BITS-1:0] chained_cnt;

    // ==============================
    // Response generation
    // ==============================

    assign walking = (links_rem != '0);

    // The FIFO keeps its head entry while a chain is in progress
    assign deq = not_empty && !walking;

    // Next pointer of the response currently on the output
    assign link_rd_idx = rsp_out.heap_idx;

    always_ff @(posedge clk)
    begin
        if (walking)
        begin
            // Same data, next read in the chain
            rsp_out.heap_idx <= link_rd_next;
            links_rem <= links_rem - chain_len_t'(1);
        end
        else
        begin
            rsp_out <= first_rsp;
            rsp_out.valid <= deq;
            links_rem <= deq ? first_len : '0;
        end

        if (reset)
        begin
            rsp_out.valid <= 1'b0;
            links_rem <= '0;
        end
    end

    // ==============================
    // Chained response accounting
    // ==============================

    always_ff @(posedge clk)
    begin
        if (link_match && !walking)
        begin
            chained_cnt <= chained_cnt + 1'b1;
        end
        else if (walking && !link_match)
        begin
            chained_cnt <= chained_cnt - 1'b1;
        end

        almost_full <= (chained_cnt >= AF_LEVEL);

        if (reset)
        begin
            chained_cnt <= '0;
            almost_full <= 1'b0;
        end
    end

endmodule

/* hw/dedup_config.svh */
// Read deduplication shim configuration
// Sizes of the address, data, heap index and tracker fields, together with
// the response FIFO depth and the almost-full margin

`ifndef DEDUP_CONFIG_SVH
`define DEDUP_CONFIG_SVH

// Line address and response data widths
`define DEDUP_ADDR_BITS 32
`define DEDUP_DATA_BITS 32

// Heap index width, so 64 reads may be active at once
`define DEDUP_HEAP_IDX_BITS 6

// Direct-mapped tracker with 2**RADIX entries
`define DEDUP_TRACKER_RADIX 4

// Chain length field, so at most 7 links behind a base read
`define DEDUP_CHAIN_LEN_BITS 3

// Response FIFO depth and the free slots kept for requests in flight
`define DEDUP_RSP_FIFO_DEPTH 32
`define DEDUP_ALMOST_FULL_MARGIN 6

`endif

/* hw/dedup_mem_pkg.sv */
// Requester and memory side types of the read deduplication shim
// Read requests, read responses and the heap index that tags each
// active read

`include "dedup_config.svh"

package dedup_mem_pkg;

    // Unique tag of an active read
    typedef logic [`DEDUP_HEAP_IDX_BITS-1:0] heap_idx_t;

    // Line address and response payload
    typedef logic [`DEDUP_ADDR_BITS-1:0] line_addr_t;
    typedef logic [`DEDUP_DATA_BITS-1:0] rsp_data_t;

    // Read request as issued by the requester and forwarded to memory
    typedef struct packed
    {
        logic valid;
        line_addr_t addr;
        heap_idx_t heap_idx;
    } rd_req_t;

    // Read response, which always names the heap index it answers
    typedef struct packed
    {
        logic valid;
        heap_idx_t heap_idx;
        rsp_data_t data;
    } rd_rsp_t;

endpackage

/* hw/dedup_read_tracker.sv */
// Read tracker
// Direct-mapped table of active reads. Flags a new read as a duplicate of
// an active read to the same line and reports the head and tail of the
// chain it joins, together with the new chain length. Results are valid
// one cycle after the request

`timescale 1ns/10ps
`include "dedup_config.svh"

module dedup_read_tracker
(
    input  logic clk,
    input  logic reset,
    input  dedup_mem_pkg::rd_req_t req_in,
    input  dedup_mem_pkg::rd_rsp_t mem_rsp,
    output logic match,
    output dedup_mem_pkg::heap_idx_t head_idx,
    output dedup_mem_pkg::heap_idx_t tail_idx,
    output dedup_track_pkg::chain_len_t chain_len
);
    import dedup_mem_pkg::*;
    import dedup_track_pkg::*;

    localparam int N_ENTRIES = 1 << `DEDUP_TRACKER_RADIX;

    // Entry storage. Only the valid bits are control state
    logic [N_ENTRIES-1:0] entry_valid;
    heap_idx_t base_idx [N_ENTRIES];
    chain_len_t entry_len [N_ENTRIES];
    tracker_state_t entry_state [N_ENTRIES];

    // Stage 0 is the request as it arrives, stage 1 is one cycle later
    addr_split_u rd_addr;
    addr_split_u wr_addr;
    tracker_state_t rd_state;
    tracker_state_t wr_state;
    logic wr_en;
    logic wr_hit;

    rd_req_t req_q;
    logic valid_q;
    logic tag_hit_q;
    logic full_q;
    tracker_state_t state_q;

    always_comb
    begin
        rd_addr.addr = req_in.addr;
        wr_addr.addr = req_q.addr;

        // Every read updates its entry in stage 1, matched or not
        wr_en = req_q.valid;
        wr_state.tag = wr_addr.split.tag;
        wr_state.latest_heap_idx = req_q.heap_idx;

        // Bypass so that back-to-back reads to one entry see each other
        wr_hit = wr_en && (wr_addr.split.idx == rd_addr.split.idx);
        rd_state = wr_hit ? wr_state : entry_state[rd_addr.split.idx];
    end

    // ==============================
    // Stage 0 valid bits
    // ==============================

    always_ff @(posedge clk)
    begin
        for (int t = 0; t < N_ENTRIES; t++)
        begin
            if (req_in.valid && rd_addr.split.idx == tracker_idx_t'(t))
            begin
                entry_valid[t] <= 1'b1;
            end

            // The base response ends the life of the entry
            if (mem_rsp.valid && base_idx[t] == mem_rsp.heap_idx)
            begin
                entry_valid[t] <= 1'b0;
            end
        end

        if (reset)
        begin
            entry_valid <= '0;
        end
    end

    // Read entry state in stage 0 and register it for the stage 1 compare
    always_ff @(posedge clk)
    begin
        req_q <= req_in;
        valid_q <= req_in.valid && entry_valid[rd_addr.split.idx];
        state_q <= rd_state;
        tag_hit_q <= (rd_state.tag == rd_addr.split.tag);

        // Stage 1 may still add one link that is not in the table yet,
        // so the low bit of the length is left out of the full test
        full_q <= &entry_len[rd_addr.split.idx][`DEDUP_CHAIN_LEN_BITS-1:1];
        if (wr_hit && !match)
        begin
            // A new chain is being started in stage 1
            full_q <= 1'b0;
        end

        if (reset)
        begin
            req_q.valid <= 1'b0;
            valid_q <= 1'b0;
        end
    end

    // ==============================
    // Stage 1 match and update
    // ==============================

    assign match = valid_q && tag_hit_q && !full_q;
    assign head_idx = base_idx[wr_addr.split.idx];
    assign tail_idx = state_q.latest_heap_idx;
    assign chain_len = entry_len[wr_addr.split.idx] + chain_len_t'(1);

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            entry_state[wr_addr.split.idx] <= wr_state;
            if (match)
            begin
                entry_len[wr_addr.split.idx] <= chain_len;
            end
            else
            begin
                // Unique read becomes the base of a fresh chain
                base_idx[wr_addr.split.idx] <= req_q.heap_idx;
                entry_len[wr_addr.split.idx] <= '0;
            end
        end
    end

endmodule

/* hw/dedup_reads_top.sv */
// Read deduplication shim, top level
// Reads to a line that is already in flight are held back and chained
// behind the base read, and the base response is replayed once per
// chained read with that read's own heap index

`timescale 1ns/10ps

module dedup_reads_top
(
    input  logic clk,
    input  logic reset,
    input  dedup_mem_pkg::rd_req_t req_in,
    output dedup_mem_pkg::rd_req_t mem_req,
    input  dedup_mem_pkg::rd_rsp_t mem_rsp,
    output dedup_mem_pkg::rd_rsp_t rsp_out,
    output logic almost_full
);
    import dedup_mem_pkg::*;
    import dedup_track_pkg::*;

    // Tracker results, one cycle after the request
    logic match;
    heap_idx_t head_idx;
    heap_idx_t tail_idx;
    chain_len_t chain_len;

    // Chain store traffic
    logic len_wr_en;
    heap_idx_t len_wr_idx;
    chain_len_t len_wr_data;
    heap_idx_t len_rd_idx;
    chain_len_t len_rd_data;
    logic link_wr_en;
    heap_idx_t link_wr_idx;
    heap_idx_t link_wr_next;
    heap_idx_t link_rd_idx;
    heap_idx_t link_rd_next;
    logic link_match;

    // FIFO to walker
    rd_rsp_t first_rsp;
    chain_len_t first_len;
    logic not_empty;
    logic deq;

    dedup_read_tracker u_tracker
    (
        .clk, .reset, .req_in, .mem_rsp,
        .match, .head_idx, .tail_idx, .chain_len
    );

    dedup_request_path u_request_path
    (
        .clk, .reset, .req_in, .match, .head_idx, .tail_idx, .chain_len,
        .mem_req, .len_wr_en, .len_wr_idx, .len_wr_data,
        .link_wr_en, .link_wr_idx, .link_wr_next, .link_match
    );

    dedup_chain_store u_chain_store
    (
        .clk, .len_wr_en, .len_wr_idx, .len_wr_data, .len_rd_idx, .len_rd_data,
        .link_wr_en, .link_wr_idx, .link_wr_next, .link_rd_idx, .link_rd_next
    );

    dedup_rsp_fifo u_rsp_fifo
    (
        .clk, .reset, .mem_rsp, .len_rd_idx, .len_rd_data,
        .first_rsp, .first_len, .not_empty, .deq
    );

    dedup_chain_walker u_chain_walker
    (
        .clk, .reset, .first_rsp, .first_len, .not_empty, .deq,
        .link_rd_idx, .link_rd_next, .link_match, .rsp_out, .almost_full
    );

endmodule

/* hw/dedup_request_path.sv */
// Request path
// Registers incoming reads, forwards only the unique ones to memory and
// issues the chain length and next-pointer writes for every read

`timescale 1ns/10ps

module dedup_request_path
(
    input  logic clk,
    input  logic reset,
    input  dedup_mem_pkg::rd_req_t req_in,
    input  logic match,
    input  dedup_mem_pkg::heap_idx_t head_idx,
    input  dedup_mem_pkg::heap_idx_t tail_idx,
    input  dedup_track_pkg::chain_len_t chain_len,
    output dedup_mem_pkg::rd_req_t mem_req,
    output logic len_wr_en,
    output dedup_mem_pkg::heap_idx_t len_wr_idx,
    output dedup_track_pkg::chain_len_t len_wr_data,
    output logic link_wr_en,
    output dedup_mem_pkg::heap_idx_t link_wr_idx,
    output dedup_mem_pkg::heap_idx_t link_wr_next,
    output logic link_match
);
    import dedup_mem_pkg::*;

    rd_req_t req_q;
    logic match_qq;
    heap_idx_t tail_qq;
    heap_idx_t new_idx_qq;

    always_ff @(posedge clk)
    begin
        req_q <= req_in;

        // Duplicates are dropped here and never reach memory
        mem_req <= req_q;
        mem_req.valid <= req_q.valid && !match;

        // The link write is held back to stage qq
        match_qq <= match;
        tail_qq <= tail_idx;
        new_idx_qq <= req_q.heap_idx;

        if (reset)
        begin
            req_q.valid <= 1'b0;
            mem_req.valid <= 1'b0;
            match_qq <= 1'b0;
        end
    end

    // A unique read opens a chain of length zero at its own index, a
    // duplicate bumps the length stored at the head
    assign len_wr_en = req_q.valid;
    assign len_wr_idx = match ? head_idx : req_q.heap_idx;
    assign len_wr_data = match ? chain_len : '0;

    // Append the duplicate behind the current tail
    assign link_wr_en = match_qq;
    assign link_wr_idx = tail_qq;
    assign link_wr_next = new_idx_qq;
    assign link_match = match_qq;

endmodule

/* hw/dedup_rsp_fifo.sv */
// Response FIFO
// Delays memory responses by two stages so that the last links of a
// chain are written before the base response is queued, then stores each
// response with its chain length. First word fall-through

`timescale 1ns/10ps
`include "dedup_config.svh"

module dedup_rsp_fifo
(
    input  logic clk,
    input  logic reset,
    input  dedup_mem_pkg::rd_rsp_t mem_rsp,
    output dedup_mem_pkg::heap_idx_t len_rd_idx,
    input  dedup_track_pkg::chain_len_t len_rd_data,
    output dedup_mem_pkg::rd_rsp_t first_rsp,
    output dedup_track_pkg::chain_len_t first_len,
    output logic not_empty,
    input  logic deq
);
    import dedup_mem_pkg::*;
    import dedup_track_pkg::*;

    localparam int PTR_BITS = $clog2(`DEDUP_RSP_FIFO_DEPTH);

    typedef struct packed
    {
        rd_rsp_t rsp;
        chain_len_t len;
    } fifo_entry_t;

    rd_rsp_t rsp_d1;
    rd_rsp_t rsp_d2;
    fifo_entry_t buffer [`DEDUP_RSP_FIFO_DEPTH];

    // Extra top bit tells a wrapped write pointer from an empty buffer
    logic [PTR_BITS:0] wr_ptr;
    logic [PTR_BITS:0] rd_ptr;

    always_ff @(posedge clk)
    begin
        rsp_d1 <= mem_rsp;
        rsp_d2 <= rsp_d1;

        if (reset)
        begin
            rsp_d1.valid <= 1'b0;
            rsp_d2.valid <= 1'b0;
        end
    end

    // Length RAM answers one cycle later, in line with rsp_d2
    assign len_rd_idx = rsp_d1.heap_idx;

    always_ff @(posedge clk)
    begin
        if (rsp_d2.valid)
        begin
            buffer[wr_ptr[PTR_BITS-1:0]] <= '{rsp: rsp_d2, len: len_rd_data};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rsp_d2.valid)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (deq)
        begin
            rd_ptr <= rd_ptr + 1'b1;
        end

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
    end

    assign not_empty = (wr_ptr != rd_ptr);
    assign first_rsp = buffer[rd_ptr[PTR_BITS-1:0]].rsp;
    assign first_len = buffer[rd_ptr[PTR_BITS-1:0]].len;

endmodule

/* hw/dedup_track_pkg.sv */
// Tracker and chain types of the read deduplication shim
// Address split into tag and tracker index, tracker entry state and
// the chain length carried with every base read

`include "dedup_config.svh"

package dedup_track_pkg;

    // Number of links queued behind a base read
    typedef logic [`DEDUP_CHAIN_LEN_BITS-1:0] chain_len_t;

    // Direct-mapped tracker index and the tag left over above it
    typedef logic [`DEDUP_TRACKER_RADIX-1:0] tracker_idx_t;
    typedef logic [`DEDUP_ADDR_BITS-`DEDUP_TRACKER_RADIX-1:0] tracker_tag_t;

    // The same address word, seen whole or as tag plus index
    typedef union packed
    {
        dedup_mem_pkg::line_addr_t addr;
        struct packed
        {
            tracker_tag_t tag;
            tracker_idx_t idx;
        } split;
    } addr_split_u;

    // Per-entry state. The latest heap index is the tail of the chain
    typedef struct packed
    {
        tracker_tag_t tag;
        dedup_mem_pkg::heap_idx_t latest_heap_idx;
    } tracker_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build the read deduplication testbench with Verilator and run it.
# The run counts as passed only when the pass line shows up in its output.
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tb_dedup_reads \
        -f filelist.f -o tb_dedup_reads \
    && ./obj_dir/tb_dedup_reads | tee /dev/stderr | grep -q -F "PASS: all tests" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb/tb_dedup_reads.sv */
// Testbench for the read deduplication shim
// Issues reads from a pool of heap indices, models an in-order memory
// with random latency and checks every response against reference data

`timescale 1ns/10ps
`include "dedup_config.svh"

module tb_dedup_reads;
    import dedup_mem_pkg::*;

    localparam int N_IDX = 1 << `DEDUP_HEAP_IDX_BITS;
    localparam int TOTAL_REQS = 20 + 4 + 2 + 12 + 2000;
    localparam int TIMEOUT_CYCLES = TOTAL_REQS * 200 + 1000;

    logic clk;
    logic reset;
    rd_req_t req_in;
    rd_req_t mem_req;
    rd_rsp_t mem_rsp;
    rd_rsp_t rsp_out;
    logic almost_full;

    // Scoreboard of active reads, indexed by heap index
    logic [N_IDX-1:0] active;
    line_addr_t idx_addr [N_IDX];
    int mem_delay [N_IDX];
    int rsp_cycle [N_IDX];
    heap_idx_t issued_q [$];

    int cycle = 0;
    int issued_count = 0;
    int mem_req_count = 0;
    int rsp_count = 0;
    int issued_start;
    int mem_req_start;
    int rsp_start;

    dedup_reads_top DUT
    (
        .clk, .reset, .req_in, .mem_req, .mem_rsp, .rsp_out, .almost_full
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // Reference contents of memory, every address bit changes the data
    function automatic rsp_data_t mem_data(input line_addr_t addr);
        rsp_data_t h;
        h = addr * 32'h9e37_79b1;
        h = h ^ (h >> 13) ^ {addr[7:0], addr[31:8]};
        return h;
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected)
        begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            stop_run();
        end
    endtask

    // ==============================
    // Requester side
    // ==============================

    // Waits for almost_full low and a free heap index, then presents the read
    task automatic issue_read(input line_addr_t addr);
        heap_idx_t idx;
        logic found;
        int start;
        int i;
        found = 1'b0;
        idx = '0;
        while (!found)
        begin
            @(posedge clk);
            req_in <= '0;
            if (!almost_full)
            begin
                start = int'($urandom % N_IDX);
                for (i = 0; i < N_IDX && !found; i++)
                begin
                    if (!active[(start + i) % N_IDX])
                    begin
                        idx = heap_idx_t'((start + i) % N_IDX);
                        found = 1'b1;
                    end
                end
            end
        end
        req_in <= '{valid: 1'b1, addr: addr, heap_idx: idx};
        active[idx] <= 1'b1;
        idx_addr[idx] = addr;
        // Memory latency of this read
        mem_delay[idx] = 20 + int'($urandom % 21);
        issued_count++;
        issued_q.push_back(idx);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        req_in <= '0;
    endtask

    task automatic begin_test(input string name);
        $display("Running %s", name);
        issued_q.delete();
        issued_start = issued_count;
        mem_req_start = mem_req_count;
        rsp_start = rsp_count;
    endtask

    // Lets every active read finish and checks one response per read
    task automatic end_test();
        idle_cycle();
        while (active != '0)
        begin
            idle_cycle();
        end
        repeat (8) idle_cycle();
        check_value("response count", rsp_count - rsp_start, issued_count - issued_start);
    endtask

    // ==============================
    // Memory model
    // ==============================

    initial
    begin
        line_addr_t q_addr [$];
        heap_idx_t q_idx [$];
        int q_due [$];
        rd_req_t req_d1;
        rd_req_t req_d2;
        int due;
        int last_due;
        mem_rsp = '0;
        req_d1 = '0;
        req_d2 = '0;
        last_due = 0;
        forever
        begin
            @(posedge clk);
            mem_rsp <= '0;
            if (!reset && mem_req.valid)
            begin
                // A forwarded read must be the one presented 2 cycles before
                check_value("req_in.valid 2 cycles before mem_req", req_d2.valid, 1'b1);
                check_value("mem_req.heap_idx", mem_req.heap_idx, req_d2.heap_idx);
                check_value("mem_req.addr", mem_req.addr, req_d2.addr);
                mem_req_count++;
                due = cycle + mem_delay[mem_req.heap_idx];
                if (due <= last_due)
                begin
                    due = last_due + 1;
                end
                last_due = due;
                q_addr.push_back(mem_req.addr);
                q_idx.push_back(mem_req.heap_idx);
                q_due.push_back(due);
            end
            // Responses leave in request order, at most one per cycle
            if (q_due.size() != 0 && q_due[0] <= cycle)
            begin
                check_value("active[mem_rsp.heap_idx]", active[q_idx[0]], 1'b1);
                mem_rsp <= '{valid: 1'b1, heap_idx: q_idx[0], data: mem_data(q_addr[0])};
                void'(q_addr.pop_front());
                void'(q_idx.pop_front());
                void'(q_due.pop_front());
            end
            req_d2 = req_d1;
            req_d1 = req_in;
        end
    end

    // ==============================
    // Response checker
    // ==============================

    always @(posedge clk)
    begin
        if (!reset && rsp_out.valid)
        begin
            check_value("active[rsp_out.heap_idx]", active[rsp_out.heap_idx], 1'b1);
            check_value("rsp_out.data", rsp_out.data, mem_data(idx_addr[rsp_out.heap_idx]));
            active[rsp_out.heap_idx] <= 1'b0;
            rsp_cycle[rsp_out.heap_idx] = cycle;
            rsp_count++;
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("ERROR: timeout after %0d cycles, %0d reads issued and %0d answered",
                 TIMEOUT_CYCLES, issued_count, rsp_count);
        stop_run();
    end

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        int k;
        int n;
        void'($urandom(32'h92fd));
        reset = 1'b1;
        req_in = '0;
        active = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("almost_full", almost_full, 1'b0);
        check_value("mem_req.valid", mem_req.valid, 1'b0);
        check_value("rsp_out.valid", rsp_out.valid, 1'b0);

        begin_test("distinct lines");
        for (k = 0; k < 20; k++)
        begin
            issue_read(32'h0000_1000 + k * 32'h0000_0107);
        end
        end_test();
        check_value("mem_req count", mem_req_count - mem_req_start, 20);

        // Base read then three chained reads, replayed on consecutive cycles
        begin_test("one line, four reads");
        repeat (4) issue_read(32'h00ab_cd40);
        end_test();
        check_value("mem_req count", mem_req_count - mem_req_start, 1);
        for (k = 1; k < 4; k++)
        begin
            check_value("rsp_out cycle after base",
                        rsp_cycle[issued_q[k]] - rsp_cycle[issued_q[0]], k);
        end

        begin_test("same tracker entry, other tag");
        issue_read(32'h0000_0125);
        issue_read(32'h0000_3a25);
        end_test();
        check_value("mem_req count", mem_req_count - mem_req_start, 2);

        begin_test("chain full");
        repeat (12) issue_read(32'h0055_0070);
        end_test();
        check_value("mem_req count above one", (mem_req_count - mem_req_start) > 1, 1'b1);

        // Eight lines over four tracker entries, so duplicates and tag misses mix
        begin_test("random stream");
        for (k = 0; k < 2000; k++)
        begin
            if ($urandom % 4 == 0)
            begin
                idle_cycle();
            end
            n = int'($urandom % 8);
            issue_read(((n >= 4) ? 32'h0012_3400 : 32'h0000_0a00) | (n % 4));
        end
        end_test();

        $display("Issued %0d reads, %0d reached memory, %0d responses",
                 issued_count, mem_req_count, rsp_count);
        $display("PASS: all tests");
        $finish;
    end

endmodule
